//--- hdl/rv64_pkg.sv
`default_nettype none

package rv64_pkg;

   localparam int xlen      = 64;         // register and data width
   localparam int vaddr_w   = 39;         // sv39 sized pc / bus address
   localparam int ilen      = 32;         // instruction width
   localparam int reg_idx_w = 5;          // x0..x31

   // major opcodes, bits [6:0] of the instruction
   typedef enum logic [6:0] {
      op_lui    = 7'b0110111,
      op_auipc  = 7'b0010111,
      op_load   = 7'b0000011,
      op_store  = 7'b0100011,
      op_imm    = 7'b0010011,
      op_imm_w  = 7'b0011011,
      op_reg    = 7'b0110011,
      op_reg_w  = 7'b0111011,
      op_jal    = 7'b1101111,
      op_jalr   = 7'b1100111,
      op_branch = 7'b1100011
   } opcode_e;

   typedef enum logic [4:0] {
      alu_add,
      alu_sub,
      alu_xor,
      alu_or,
      alu_and,
      alu_sll,
      alu_srl,
      alu_sra,
      alu_slt,
      alu_sltu,
      alu_pass_b,                        // lui
      alu_none                           // unknown encoding, no writeback
   } alu_op_e;

   // funct3 of loads and stores, also driven as bus_ls_type
   // 0 b, 1 h, 2 w, 3 d, 4 bu, 5 hu, 6 wu
   typedef logic [2:0] ls_size_t;

   localparam logic [ilen-1:0] nop_instr = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire

//--- hdl/rv64_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_fetch
   import rv64_pkg::*;
#(
   parameter logic [vaddr_w-1:0] reset_pc = 39'h0000_2000_0
) (
   input  wire                clk,
   input  wire                reset,
   input  wire  [ilen-1:0]    instruction_i,   // word at pc_o, same cycle
   input  wire                redirect_i,      // taken branch or jump in execute
   input  wire  [vaddr_w-1:0] target_i,
   input  wire                hold_i,          // lsu busy on the bus
   output logic [vaddr_w-1:0] pc_o,
   output logic [ilen-1:0]    ir_o,
   output logic               exec_valid_o
);

   logic [vaddr_w-1:0] pc_q;
   logic [ilen-1:0]    ir_q;
   logic               valid_q;

   // pc and ir advance together, ir runs one word behind pc
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         pc_q    <= reset_pc;
         ir_q    <= nop_instr;
         valid_q <= 1'b0;             // nothing to execute yet
      end else if (hold_i) begin
         // load/store outstanding, freeze both
         pc_q    <= pc_q;
         ir_q    <= ir_q;
         valid_q <= valid_q;
      end else if (redirect_i) begin
         pc_q    <= target_i;
         ir_q    <= instruction_i;    // wrong path word
         valid_q <= 1'b0;             // bubble, squash it
      end else begin
         pc_q    <= pc_q + vaddr_w'(4);
         ir_q    <= instruction_i;
         valid_q <= 1'b1;
      end
   end

   assign pc_o         = pc_q;         // already ir address + 4 during execute
   assign ir_o         = ir_q;
   assign exec_valid_o = valid_q;

endmodule

`default_nettype wire

//--- hdl/rv64_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_decode
   import rv64_pkg::*;
(
   input  wire  [ilen-1:0]      ir_i,
   output opcode_e              opcode_o,
   output ls_size_t             funct3_o,
   output logic [reg_idx_w-1:0] rd_o,
   output logic [reg_idx_w-1:0] rs1_o,
   output logic [reg_idx_w-1:0] rs2_o,
   output logic [xlen-1:0]      imm_o,
   output alu_op_e              alu_op_o,
   output logic                 word_op_o
);

   logic [xlen-1:0] imm_u, imm_i, imm_s, imm_j, imm_b;
   logic            alt;                 // funct7 bit 5 picks sub / sra

   assign opcode_o = opcode_e'(ir_i[6:0]); // unknown values fall through as no-op
   assign funct3_o = ir_i[14:12];
   assign rd_o     = ir_i[11:7];
   assign rs1_o    = ir_i[19:15];
   assign rs2_o    = ir_i[24:20];
   assign alt      = ir_i[30];

   // immediates are sign extended from bit 31
   assign imm_u = {{32{ir_i[31]}}, ir_i[31:12], 12'b0};
   assign imm_i = {{52{ir_i[31]}}, ir_i[31:20]};
   assign imm_s = {{52{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
   assign imm_j = {{44{ir_i[31]}}, ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
   assign imm_b = {{52{ir_i[31]}}, ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};

   assign word_op_o = (opcode_o == op_imm_w) || (opcode_o == op_reg_w);

   always_comb begin
      case (opcode_o)
         op_lui, op_auipc: imm_o = imm_u;
         op_store:         imm_o = imm_s;
         op_jal:           imm_o = imm_j;
         op_branch:        imm_o = imm_b;
         default:          imm_o = imm_i;   // loads, jalr, op-imm
      endcase
   end

   // funct3 / funct7 to alu function
   always_comb begin
      alu_op_o = alu_none;
      case (opcode_o)
         op_lui:   alu_op_o = alu_pass_b;
         op_auipc: alu_op_o = alu_add;      // pc - 4 + imm
         op_imm, op_reg: begin
            case (funct3_o)
               3'd0: alu_op_o = (opcode_o == op_reg && alt) ? alu_sub : alu_add;
               3'd1: alu_op_o = alu_sll;
               3'd2: alu_op_o = alu_slt;
               3'd3: alu_op_o = alu_sltu;
               3'd4: alu_op_o = alu_xor;
               3'd5: alu_op_o = alt ? alu_sra : alu_srl;
               3'd6: alu_op_o = alu_or;
               default: alu_op_o = alu_and;
            endcase
         end
         op_imm_w, op_reg_w: begin           // only add/sub and shifts exist
            case (funct3_o)
               3'd0: alu_op_o = (opcode_o == op_reg_w && alt) ? alu_sub : alu_add;
               3'd1: alu_op_o = alu_sll;
               3'd5: alu_op_o = alt ? alu_sra : alu_srl;
               default: alu_op_o = alu_none;
            endcase
         end
         default: alu_op_o = alu_none;      // jumps, branches, load/store
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/rv64_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_regfile
   import rv64_pkg::*;
(
   input  wire                  clk,
   input  wire                  reset,
   input  wire  [reg_idx_w-1:0] rs1_i,
   input  wire  [reg_idx_w-1:0] rs2_i,
   output logic [xlen-1:0]      rs1_data_o,
   output logic [xlen-1:0]      rs2_data_o,
   input  wire  [reg_idx_w-1:0] rd_i,
   input  wire                  alu_we_i,
   input  wire  [xlen-1:0]      alu_data_i,
   input  wire                  load_we_i,
   input  wire  [xlen-1:0]      load_data_i
);

   logic [xlen-1:0] regs [0:31];

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if ((alu_we_i || load_we_i) && rd_i != '0) begin // x0 stays zero
         regs[rd_i] <= load_we_i ? load_data_i : alu_data_i;    // never both at once
      end
   end

   assign rs1_data_o = regs[rs1_i];
   assign rs2_data_o = regs[rs2_i];

endmodule

`default_nettype wire

//--- hdl/rv64_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_alu
   import rv64_pkg::*;
(
   input  wire                exec_valid_i,
   input  opcode_e            opcode_i,
   input  alu_op_e            alu_op_i,
   input  wire                word_op_i,
   input  ls_size_t           funct3_i,
   input  wire  [xlen-1:0]    rs1_data_i,
   input  wire  [xlen-1:0]    rs2_data_i,
   input  wire  [xlen-1:0]    imm_i,
   input  wire  [vaddr_w-1:0] pc_i,           // ir address + 4
   output logic               wb_we_o,
   output logic [xlen-1:0]    wb_data_o,
   output logic               redirect_o,
   output logic [vaddr_w-1:0] target_o
);

   logic [xlen-1:0] pc_ext, this_pc;
   logic [xlen-1:0] op_a, op_b, op_a_w;
   logic [5:0]      shamt;
   logic [xlen-1:0] res;
   logic [xlen-1:0] tgt;
   logic            is_jump, is_arith, taken;

   assign pc_ext  = {{(xlen - vaddr_w){1'b0}}, pc_i};
   assign this_pc = pc_ext - xlen'(4);        // address of the executing word

   assign op_a = (opcode_i == op_auipc) ? this_pc : rs1_data_i;
   assign op_b = (opcode_i == op_reg || opcode_i == op_reg_w) ? rs2_data_i : imm_i;

   // word forms shift the low half, sra needs its sign
   assign op_a_w = !word_op_i           ? op_a :
                   (alu_op_i == alu_sra) ? {{32{op_a[31]}}, op_a[31:0]} :
                                          {32'b0, op_a[31:0]};
   assign shamt  = word_op_i ? {1'b0, op_b[4:0]} : op_b[5:0];

   always_comb begin
      case (alu_op_i)
         alu_add:    res = op_a + op_b;
         alu_sub:    res = op_a - op_b;
         alu_xor:    res = op_a ^ op_b;
         alu_or:     res = op_a | op_b;
         alu_and:    res = op_a & op_b;
         alu_sll:    res = op_a << shamt;
         alu_srl:    res = op_a_w >> shamt;
         alu_sra:    res = $signed(op_a_w) >>> shamt;
         alu_slt:    res = {63'b0, $signed(op_a) < $signed(op_b)};
         alu_sltu:   res = {63'b0, op_a < op_b};
         alu_pass_b: res = op_b;
         default:    res = '0;
      endcase
   end

   assign is_jump  = (opcode_i == op_jal) || (opcode_i == op_jalr);
   assign is_arith = (opcode_i == op_lui) || (opcode_i == op_auipc) ||
                     (opcode_i == op_imm) || (opcode_i == op_imm_w) ||
                     (opcode_i == op_reg) || (opcode_i == op_reg_w);

   // writeback, link for jumps, word results sign extended
   assign wb_we_o   = exec_valid_i && (is_jump || (is_arith && alu_op_i != alu_none));
   assign wb_data_o = is_jump   ? pc_ext :
                      word_op_i ? {{32{res[31]}}, res[31:0]} : res;

   always_comb begin
      case (funct3_i)
         3'd0:    taken = rs1_data_i == rs2_data_i;                    // beq
         3'd1:    taken = rs1_data_i != rs2_data_i;                    // bne
         3'd4:    taken = $signed(rs1_data_i) < $signed(rs2_data_i);   // blt
         3'd5:    taken = $signed(rs1_data_i) >= $signed(rs2_data_i);  // bge
         3'd6:    taken = rs1_data_i < rs2_data_i;                     // bltu
         3'd7:    taken = rs1_data_i >= rs2_data_i;                    // bgeu
         default: taken = 1'b0;
      endcase
   end

   assign tgt = (opcode_i == op_jalr) ? ((rs1_data_i + imm_i) & ~xlen'(1))
                                      : this_pc + imm_i;              // jal, branch

   assign redirect_o = exec_valid_i &&
                       (is_jump || (opcode_i == op_branch && taken));
   assign target_o   = redirect_o ? tgt[vaddr_w-1:0] : '0;

endmodule

`default_nettype wire

//--- hdl/rv64_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_lsu
   import rv64_pkg::*;
(
   input  wire                clk,
   input  wire                reset,
   input  wire                exec_valid_i,
   input  opcode_e            opcode_i,
   input  ls_size_t           funct3_i,
   input  wire  [xlen-1:0]    rs1_data_i,
   input  wire  [xlen-1:0]    rs2_data_i,
   input  wire  [xlen-1:0]    imm_i,
   output logic               hold_o,
   output logic               load_we_o,
   output logic [xlen-1:0]    load_data_o,
   output logic [vaddr_w-1:0] bus_address_o,
   output logic [xlen-1:0]    bus_write_data_o,
   output logic               bus_write_enable_o,
   output logic               bus_read_enable_o,
   output ls_size_t           bus_ls_type_o,
   input  wire                bus_read_done_i,
   input  wire                bus_write_done_i,
   input  wire  [xlen-1:0]    bus_read_data_i
);

   typedef enum logic {st_idle, st_wait} state_e;

   state_e          state_q;
   logic            is_load, start, done;
   logic [xlen-1:0] eff_addr;

   assign is_load = (opcode_i == op_load);
   assign start   = exec_valid_i && (is_load || opcode_i == op_store);
   assign done    = is_load ? bus_read_done_i : bus_write_done_i; // matching pulse only

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state_q <= st_idle;
      end else begin
         case (state_q)
            st_idle: if (start) state_q <= st_wait;
            st_wait: if (done)  state_q <= st_idle;
            default: state_q <= st_idle;
         endcase
      end
   end

   // one enable pulse in the first execute cycle, never reissued
   assign bus_read_enable_o  = (state_q == st_idle) && start && is_load;
   assign bus_write_enable_o = (state_q == st_idle) && start && !is_load;

   // freeze fetch until the done cycle, ir advances at that edge
   assign hold_o = ((state_q == st_idle) && start) || ((state_q == st_wait) && !done);

   // ir and sources are frozen while waiting, so these hold until done
   assign eff_addr      = rs1_data_i + imm_i;
   assign bus_address_o = eff_addr[vaddr_w-1:0];
   assign bus_ls_type_o = funct3_i;

   always_comb begin
      case (funct3_i[1:0])
         2'd0:    bus_write_data_o = {56'b0, rs2_data_i[7:0]};   // sb
         2'd1:    bus_write_data_o = {48'b0, rs2_data_i[15:0]};  // sh
         2'd2:    bus_write_data_o = {32'b0, rs2_data_i[31:0]};  // sw
         default: bus_write_data_o = rs2_data_i;                 // sd
      endcase
   end

   // read done ends the load, write back in the same cycle
   assign load_we_o = (state_q == st_wait) && is_load && bus_read_done_i;

   always_comb begin
      case (funct3_i)
         3'd0:    load_data_o = {{56{bus_read_data_i[7]}}, bus_read_data_i[7:0]};
         3'd1:    load_data_o = {{48{bus_read_data_i[15]}}, bus_read_data_i[15:0]};
         3'd2:    load_data_o = {{32{bus_read_data_i[31]}}, bus_read_data_i[31:0]};
         3'd4:    load_data_o = {56'b0, bus_read_data_i[7:0]};   // lbu
         3'd5:    load_data_o = {48'b0, bus_read_data_i[15:0]};  // lhu
         3'd6:    load_data_o = {32'b0, bus_read_data_i[31:0]};  // lwu
         default: load_data_o = bus_read_data_i;                 // ld
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/rv64_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_core
   import rv64_pkg::*;
#(
   parameter logic [vaddr_w-1:0] reset_pc = 39'h0000_2000_0
) (
   input  wire                clk,
   input  wire                reset,              // active low
   input  wire  [ilen-1:0]    instruction_i,
   output logic [vaddr_w-1:0] pc_o,
   output logic [vaddr_w-1:0] bus_address_o,
   output logic [xlen-1:0]    bus_write_data_o,
   output logic               bus_write_enable_o,
   output logic               bus_read_enable_o,
   output ls_size_t           bus_ls_type_o,
   input  wire                bus_read_done_i,
   input  wire                bus_write_done_i,
   input  wire  [xlen-1:0]    bus_read_data_i
);

   logic [ilen-1:0]      ir;
   logic                 exec_valid, redirect, hold;
   logic [vaddr_w-1:0]   target;
   opcode_e              opcode;
   ls_size_t             funct3;
   logic [reg_idx_w-1:0] rd, rs1, rs2;
   logic [xlen-1:0]      imm, rs1_data, rs2_data;
   alu_op_e              alu_op;
   logic                 word_op;
   logic                 wb_we, load_we;
   logic [xlen-1:0]      wb_data, load_data;

   rv64_fetch #(.reset_pc(reset_pc)) fetch_i (
      .clk, .reset, .instruction_i,
      .redirect_i(redirect), .target_i(target), .hold_i(hold),
      .pc_o, .ir_o(ir), .exec_valid_o(exec_valid)
   );

   rv64_decode decode_i (
      .ir_i(ir), .opcode_o(opcode), .funct3_o(funct3),
      .rd_o(rd), .rs1_o(rs1), .rs2_o(rs2), .imm_o(imm),
      .alu_op_o(alu_op), .word_op_o(word_op)
   );

   rv64_regfile regfile_i (
      .clk, .reset, .rs1_i(rs1), .rs2_i(rs2),
      .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .rd_i(rd),
      .alu_we_i(wb_we), .alu_data_i(wb_data),
      .load_we_i(load_we), .load_data_i(load_data)
   );

   rv64_alu alu_i (
      .exec_valid_i(exec_valid), .opcode_i(opcode), .alu_op_i(alu_op),
      .word_op_i(word_op), .funct3_i(funct3),
      .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_i(imm), .pc_i(pc_o),
      .wb_we_o(wb_we), .wb_data_o(wb_data), .redirect_o(redirect), .target_o(target)
   );

   rv64_lsu lsu_i (
      .clk, .reset, .exec_valid_i(exec_valid), .opcode_i(opcode), .funct3_i(funct3),
      .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_i(imm),
      .hold_o(hold), .load_we_o(load_we), .load_data_o(load_data),
      .bus_address_o, .bus_write_data_o, .bus_write_enable_o, .bus_read_enable_o,
      .bus_ls_type_o, .bus_read_done_i, .bus_write_done_i, .bus_read_data_i
   );

endmodule

`default_nettype wire

//--- tests/rv64_core_tests.svh
`ifndef RV64_CORE_TESTS_SVH
`define RV64_CORE_TESTS_SVH

   task automatic fill_tests();
      for (int t = 0; t < n_tests; t++) begin
         for (int k = 0; k < max_words; k++) prog[t][k] = nop_word;
         for (int k = 0; k < max_st; k++) begin
            st_addr[t][k] = '0;
            st_data[t][k] = '0;
            st_type[t][k] = '0;
         end
         load_word[t] = 64'h0;
         n_stores[t]  = 1;
         st_addr[t][0] = result_addr;
         st_type[t][0] = 3'd3;                                  // result is always sd
      end
      test_name[0] = "alu";
      prog[0][0]  = itype(12'd5, 5'd0, 3'd0, 5'd1, opc_imm);            // x1 = 5
      prog[0][1]  = utype(20'h12345, 5'd2, opc_lui);
      prog[0][2]  = rtype(7'h20, 5'd1, 5'd2, 3'd0, 5'd3, opc_reg);       // sub
      prog[0][3]  = rtype(7'h00, 5'd1, 5'd3, 3'd4, 5'd4, opc_reg);       // xor
      prog[0][4]  = itype(12'hff8, 5'd0, 3'd0, 5'd5, opc_imm);           // x5 = -8
      prog[0][5]  = rtype(7'h00, 5'd1, 5'd5, 3'd2, 5'd8, opc_reg);       // slt -> 1
      prog[0][6]  = rtype(7'h00, 5'd5, 5'd1, 3'd3, 5'd9, opc_reg);       // sltu -> 1
      prog[0][7]  = rtype(7'h00, 5'd1, 5'd4, 3'd1, 5'd6, opc_reg);       // sll by 5
      prog[0][8]  = rtype(7'h20, 5'd8, 5'd5, 3'd5, 5'd7, opc_reg);       // sra -> -4
      prog[0][9]  = itype(12'h7ff, 5'd2, 3'd0, 5'd10, opc_imm_w);        // addiw
      prog[0][10] = rtype(7'h20, 5'd10, 5'd1, 3'd0, 5'd11, opc_reg_w);   // subw
      prog[0][11] = rtype(7'h20, 5'd9, 5'd11, 3'd5, 5'd12, opc_reg_w);   // sraw by 1
      prog[0][12] = rtype(7'h00, 5'd12, 5'd6, 3'd4, 5'd13, opc_reg);
      prog[0][13] = rtype(7'h00, 5'd7, 5'd13, 3'd0, 5'd14, opc_reg);
      prog[0][14] = stype(12'h200, 5'd14, 5'd0, 3'd3);
      prog[0][15] = jtype(21'd0, 5'd0);                                  // spin
      st_data[0][0] = 64'hffff_fffd_b06c_2bbf;

      test_name[1] = "branch";
      prog[1][0]  = itype(12'd1, 5'd0, 3'd0, 5'd1, opc_imm);
      prog[1][1]  = btype(13'd8, 5'd0, 5'd1, 3'd0);       // beq, not taken
      prog[1][2]  = itype(12'd2, 5'd1, 3'd0, 5'd1, opc_imm);
      prog[1][3]  = btype(13'd8, 5'd0, 5'd1, 3'd1);       // bne, taken
      prog[1][4]  = itype(12'h100, 5'd1, 3'd0, 5'd1, opc_imm);   // poison, squashed
      prog[1][5]  = btype(13'd8, 5'd1, 5'd0, 3'd4);       // blt 0 < 3 taken
      prog[1][6]  = itype(12'h200, 5'd1, 3'd0, 5'd1, opc_imm);
      prog[1][7]  = btype(13'd8, 5'd1, 5'd0, 3'd7);       // bgeu, not taken
      prog[1][8]  = jtype(21'd8, 5'd2);                   // link 0x20024
      prog[1][9]  = itype(12'h400, 5'd1, 3'd0, 5'd1, opc_imm);
      prog[1][10] = itype(12'd17, 5'd2, 3'd0, 5'd0, opc_jalr);   // odd target, bit 0 dropped
      prog[1][11] = itype(12'h080, 5'd1, 3'd0, 5'd1, opc_imm);
      prog[1][12] = itype(12'h040, 5'd1, 3'd0, 5'd1, opc_imm);
      prog[1][13] = rtype(7'h00, 5'd2, 5'd1, 3'd0, 5'd1, opc_reg);
      prog[1][14] = stype(12'h200, 5'd1, 5'd0, 3'd3);
      prog[1][15] = jtype(21'd0, 5'd0);
      st_data[1][0] = 64'h0000_0000_0002_0027;             // 3 + link

      test_name[2] = "load";
      load_word[2] = 64'h8765_4321_fedc_ba98;
      for (int k = 0; k < 7; k++) begin                   // lb lh lw ld lbu lhu lwu
         prog[2][k] = itype(12'h100, 5'd0, 3'(k), 5'(k + 1), opc_load);
      end
      prog[2][7]  = rtype(7'h00, 5'd5, 5'd1, 3'd0, 5'd8, opc_reg);    // lb + lbu
      prog[2][8]  = rtype(7'h00, 5'd6, 5'd2, 3'd4, 5'd9, opc_reg);    // lh ^ lhu
      prog[2][9]  = rtype(7'h20, 5'd7, 5'd3, 3'd0, 5'd10, opc_reg);   // lw - lwu
      prog[2][10] = rtype(7'h00, 5'd9, 5'd8, 3'd4, 5'd11, opc_reg);
      prog[2][11] = rtype(7'h00, 5'd4, 5'd10, 3'd0, 5'd12, opc_reg);  // + ld
      prog[2][12] = rtype(7'h00, 5'd12, 5'd11, 3'd4, 5'd13, opc_reg);
      prog[2][13] = stype(12'h200, 5'd13, 5'd0, 3'd3);
      prog[2][14] = jtype(21'd0, 5'd0);
      st_data[2][0] = 64'h789a_bcdf_0123_baa8;

      test_name[3] = "store";
      prog[3][0] = utype(20'habcde, 5'd1, opc_lui);
      prog[3][1] = itype(12'h123, 5'd1, 3'd0, 5'd1, opc_imm);
      prog[3][2] = stype(12'h180, 5'd1, 5'd0, 3'd0);      // sb
      prog[3][3] = stype(12'h182, 5'd1, 5'd0, 3'd1);      // sh
      prog[3][4] = stype(12'h184, 5'd1, 5'd0, 3'd2);      // sw
      prog[3][5] = stype(12'h200, 5'd1, 5'd0, 3'd3);      // sd
      prog[3][6] = jtype(21'd0, 5'd0);
      n_stores[3] = 4;
      st_addr[3][0] = 39'h180;
      st_data[3][0] = 64'h23;
      st_type[3][0] = 3'd0;
      st_addr[3][1] = 39'h182;
      st_data[3][1] = 64'he123;
      st_type[3][1] = 3'd1;
      st_addr[3][2] = 39'h184;
      st_data[3][2] = 64'habcd_e123;
      st_type[3][2] = 3'd2;
      st_addr[3][3] = result_addr;
      st_data[3][3] = 64'hffff_ffff_abcd_e123;
      st_type[3][3] = 3'd3;
   endtask

`endif

//--- tests/rv64_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_core_tb;

   localparam int n_tests   = 4;
   localparam int max_words = 16;
   localparam int max_st    = 4;
   localparam logic [38:0] start_pc    = 39'h0000_2000_0;
   localparam logic [38:0] load_addr   = 39'h100;   // seeded data word
   localparam logic [38:0] result_addr = 39'h200;   // last store of every program
   localparam logic [31:0] nop_word    = 32'h0000_0013;

   // major opcodes, straight from the isa manual
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_load   = 7'b0000011;
   localparam logic [6:0] opc_imm    = 7'b0010011;
   localparam logic [6:0] opc_imm_w  = 7'b0011011;
   localparam logic [6:0] opc_reg    = 7'b0110011;
   localparam logic [6:0] opc_reg_w  = 7'b0111011;
   localparam logic [6:0] opc_jalr   = 7'b1100111;

   logic        clk;
   logic        reset;
   logic [31:0] instruction_i;
   logic [38:0] pc_o;
   logic [38:0] bus_address_o;
   logic [63:0] bus_write_data_o;
   logic        bus_write_enable_o;
   logic        bus_read_enable_o;
   logic [2:0]  bus_ls_type_o;
   logic        bus_read_done_i  = 1'b0;
   logic        bus_write_done_i = 1'b0;
   logic [63:0] bus_read_data_i  = 64'h0;

   // stimulus table, filled by fill_tests
   string       test_name [n_tests];
   logic [31:0] prog      [n_tests][max_words];
   logic [63:0] load_word [n_tests];
   int          n_stores  [n_tests];
   logic [38:0] st_addr   [n_tests][max_st];
   logic [63:0] st_data   [n_tests][max_st];
   logic [2:0]  st_type   [n_tests][max_st];

   int          cur_test = 0;
   int          errors   = 0;
   int          seed     = 32'h40b1a3a6;
   logic        test_done = 1'b0;
   int          n_writes  = 0;
   logic        busy      = 1'b0;          // access outstanding in memory model
   logic        busy_write = 1'b0;
   logic [38:0] busy_addr = 39'h0;
   int          wait_cnt  = 0;
   logic [38:0] pc_offs;

   rv64_core #(.reset_pc(start_pc)) dut_i (
      .clk, .reset, .instruction_i, .pc_o,
      .bus_address_o, .bus_write_data_o, .bus_write_enable_o, .bus_read_enable_o,
      .bus_ls_type_o, .bus_read_done_i, .bus_write_done_i, .bus_read_data_i
   );

   // instruction field packing
   function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

`include "rv64_core_tests.svh"

   task automatic check_value(input string sig, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         $display("mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
         errors++;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // combinational instruction memory, nop outside the program
   always_comb begin
      pc_offs = pc_o - start_pc;
      if (pc_offs[38:6] == '0) instruction_i = prog[cur_test][pc_offs[5:2]];
      else                     instruction_i = nop_word;
   end

   // data memory model, random done latency 1..4 cycles
   always @(negedge clk) begin
      if (!reset) begin
         busy             = 1'b0;
         n_writes         = 0;
         test_done        <= 1'b0;
         bus_read_done_i  <= 1'b0;
         bus_write_done_i <= 1'b0;
      end else begin
         bus_read_done_i  <= 1'b0;
         bus_write_done_i <= 1'b0;
         if (busy) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
               busy = 1'b0;
               check_value("bus_address_o", {25'b0, bus_address_o}, {25'b0, busy_addr});
               if (busy_write) begin
                  bus_write_done_i <= 1'b1;
                  if (busy_addr == result_addr) test_done <= 1'b1; // program finished
               end else begin
                  bus_read_done_i <= 1'b1;
                  bus_read_data_i <= (busy_addr == load_addr) ? load_word[cur_test] : 64'h0;
               end
            end
         end
         if (bus_read_enable_o || bus_write_enable_o) begin
            assert (!busy) else begin
               $display("enable strobe at %0t while an access was outstanding", $time);
               errors++;
            end
            busy       = 1'b1;
            busy_write = bus_write_enable_o;
            busy_addr  = bus_address_o;
            wait_cnt   = 1 + ($random(seed) & 3);
            if (bus_write_enable_o) begin
               if (n_writes < n_stores[cur_test]) begin     // compare against k-th store
                  check_value("bus_address_o", {25'b0, bus_address_o},
                              {25'b0, st_addr[cur_test][n_writes]});
                  check_value("bus_write_data_o", bus_write_data_o,
                              st_data[cur_test][n_writes]);
                  check_value("bus_ls_type_o", {61'b0, bus_ls_type_o},
                              {61'b0, st_type[cur_test][n_writes]});
               end else begin
                  $display("more write strobes at %0t than stores in the program", $time);
                  errors++;
               end
               n_writes++;
            end
         end
      end
   end

   initial begin
      int cycles;
      int errs_before;
      int n_pass;
      n_pass = 0;
      reset  = 1'b0;
      fill_tests();
      for (int t = 0; t < n_tests; t++) begin
         errs_before = errors;
         @(negedge clk);
         reset    = 1'b0;
         cur_test = t;
         repeat (3) begin
            @(negedge clk);
            check_value("pc_o", {25'b0, pc_o}, {25'b0, start_pc});   // idle after reset
            check_value("bus_read_enable_o", {63'b0, bus_read_enable_o}, 64'h0);
            check_value("bus_write_enable_o", {63'b0, bus_write_enable_o}, 64'h0);
         end
         reset  = 1'b1;
         cycles = 0;
         while (!test_done && cycles < 500) begin
            @(negedge clk);
            cycles++;
         end
         if (!test_done) begin
            $display("timeout in test %s, no store to the result address", test_name[t]);
            errors++;
         end
         check_value("write strobe count", 64'(n_writes), 64'(n_stores[t]));
         if (errors == errs_before) begin
            $display("test %s: ok (%0d cycles)", test_name[t], cycles);
            n_pass++;
         end else begin
            $display("test %s: FAILED", test_name[t]);
         end
      end
      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               n_tests, n_pass, n_tests - n_pass, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- rv64_core.f
+incdir+tests
hdl/rv64_pkg.sv
hdl/rv64_fetch.sv
hdl/rv64_decode.sv
hdl/rv64_regfile.sv
hdl/rv64_alu.sv
hdl/rv64_lsu.sv
hdl/rv64_core.sv
tests/rv64_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rv64_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv64_core.f --top-module rv64_core_tb \
   -Mdir obj_dir -o rv64_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/rv64_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
   echo "no result line in sim.log"
   exit 1
fi
exit 0
